// File: all.f
+incdir+include
hdl/eth_buf_pkg.sv
hdl/eth_word_ram.sv
hdl/eth_pkt_fifo.sv
hdl/eth_tx_framer.sv
hdl/eth_frame_buffer.sv
test/eth_frame_buffer_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := eth_frame_buffer_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/eth_frame_buffer_tb.sv
// Self-checking testbench for the Ethernet frame buffer, compiled from all.f with the Makefile
`timescale 1ns/1ns
`default_nettype none

`include "eth_buf_cfg.svh"

module eth_frame_buffer_tb;

    localparam int DEPTH     = 1 << `ETH_BUF_ADDR_WIDTH;
    localparam int QDEPTH    = `ETH_TX_QUEUE_DEPTH;
    localparam int NUM_ROWS  = 5;
    localparam int BP_OFFER  = 60;
    localparam int IDLE_WAIT = 10;
    localparam int HOLD_WAIT = 20;

    typedef struct {
        string name;
        int    frames;
        int    words;
        int    gap_pct;
        int    stall_pct;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    eth_buf_pkg::eth_word_t in_word;
    logic                   in_ready;
    logic                   out_valid;
    eth_buf_pkg::eth_word_t out_word;
    logic                   out_ready;
    eth_buf_pkg::pkt_cnt_t  pkt_count;

    row_t                   rows [NUM_ROWS];
    eth_buf_pkg::eth_word_t model_q [$];

    string cur_name;
    int    errors;
    int    tests;
    int    passed;
    int    sent;
    int    total;
    int    words_per_frame;
    int    eop_in;
    int    eop_out;
    bit    in_taken;
    bit    saw_valid;

    eth_frame_buffer eth_frame_buffer_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_ready (out_ready),
        .pkt_count (pkt_count)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    task automatic load_table();
        rows[0] = '{"short_frames", 4, 3, 0, 0};
        rows[1] = '{"single_words", 20, 1, 30, 30};
        rows[2] = '{"long_frames", 6, 12, 20, 40};
        rows[3] = '{"heavy_stall", 10, 5, 10, 80};
        rows[4] = '{"bursty_input", 8, 8, 60, 10};
    endtask

    function automatic eth_buf_pkg::eth_word_t make_word(input bit last);
        eth_buf_pkg::eth_word_t w;
        w.data     = {$urandom, $urandom};
        w.eop      = last;
        w.byte_cnt = last ? 3'($urandom) : 3'd0;
        return w;
    endfunction

    task automatic check_word(input string name, input eth_buf_pkg::eth_word_t exp,
                              input eth_buf_pkg::eth_word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected data=%h eop=%b bytes=%0d, actual data=%h eop=%b bytes=%0d",
                     name, exp.data, exp.eop, exp.byte_cnt, act.data, act.eop, act.byte_cnt);
        end
    endtask

    task automatic check_count(input string name, input eth_buf_pkg::pkt_cnt_t exp,
                               input eth_buf_pkg::pkt_cnt_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected count %0d, actual count %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected flag %b, actual flag %b", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            passed++;
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    // Outputs sampled on the falling edge decide the transfers of the next rising edge
    task automatic run_cycle(input bit allow_in, input int gap_pct, input int stall_pct);
        logic                   ready_s;
        logic                   valid_s;
        eth_buf_pkg::eth_word_t word_s;
        eth_buf_pkg::eth_word_t exp_w;
        @(negedge clk);
        ready_s = in_ready;
        valid_s = out_valid;
        word_s  = out_word;
        if (in_taken) begin
            in_valid = 1'b0;
            in_taken = 1'b0;
        end
        if (!in_valid && allow_in && sent < total && ($urandom % 100) >= gap_pct) begin
            in_word  = make_word((sent % words_per_frame) == words_per_frame - 1);
            in_valid = 1'b1;
        end
        out_ready = (($urandom % 100) >= stall_pct);
        if (in_valid && ready_s) begin
            model_q.push_back(in_word);
            if (in_word.eop) begin
                eop_in++;
            end
            sent++;
            in_taken = 1'b1;
        end
        if (valid_s) begin
            saw_valid = 1'b1;
        end
        if (valid_s && out_ready) begin
            if (model_q.size() == 0) begin
                errors++;
                $display("ERROR %s: output delivered a word that was never accepted", cur_name);
            end else begin
                exp_w = model_q.pop_front();
                check_word(cur_name, exp_w, word_s);
                if (exp_w.eop) begin
                    eop_out++;
                end
            end
        end
    endtask

    // With both streams idle and the framer queue empty pkt_count is exact
    task automatic settle_and_check(input string name);
        repeat (IDLE_WAIT) begin
            @(negedge clk);
            in_valid  = 1'b0;
            in_taken  = 1'b0;
            out_ready = 1'b1;
            if (out_valid) begin
                errors++;
                $display("ERROR %s: out_valid is high with no word left to send", name);
            end
        end
        check_count(name, eth_buf_pkg::pkt_cnt_t'(eop_in - eop_out), pkt_count);
    endtask

    task automatic run_row(input row_t r);
        int err_before;
        err_before      = errors;
        cur_name        = r.name;
        sent            = 0;
        total           = r.frames * r.words;
        words_per_frame = r.words;
        while (sent < total || model_q.size() != 0) begin
            run_cycle(1'b1, r.gap_pct, r.stall_pct);
        end
        settle_and_check(r.name);
        report_test(r.name, err_before);
    endtask

    // Hold the eop word back and watch whether the frame start leaks out
    task automatic run_mode_test();
        int   err_before;
        logic exp_seen;
        err_before      = errors;
        cur_name        = "packet_mode";
        sent            = 0;
        total           = 6;
        words_per_frame = 6;
        while (sent < total - 1) begin
            run_cycle(1'b1, 0, 0);
        end
        saw_valid = 1'b0;
        repeat (HOLD_WAIT) begin
            run_cycle(1'b0, 0, 0);
        end
        exp_seen = (`ETH_PKT_MODE == 0);
        check_flag(cur_name, exp_seen, saw_valid);
        while (sent < total || model_q.size() != 0) begin
            run_cycle(1'b1, 0, 0);
        end
        settle_and_check(cur_name);
        report_test(cur_name, err_before);
    endtask

    task automatic run_back_pressure_test();
        int err_before;
        int idle_run;
        int sent_before;
        err_before      = errors;
        cur_name        = "back_pressure";
        sent            = 0;
        total           = BP_OFFER;
        words_per_frame = 1;
        idle_run        = 0;
        while (idle_run < HOLD_WAIT && sent < total) begin
            sent_before = sent;
            run_cycle(1'b1, 0, 100);
            idle_run = (sent == sent_before) ? idle_run + 1 : 0;
        end
        check_count(cur_name, eth_buf_pkg::pkt_cnt_t'(DEPTH + QDEPTH),
                    eth_buf_pkg::pkt_cnt_t'(sent));
        // Framer queue is full of single-word frames already handed over
        check_count(cur_name, eth_buf_pkg::pkt_cnt_t'(eop_in - eop_out - QDEPTH), pkt_count);
        if (!in_taken) begin
            in_valid = 1'b0;
        end
        total = sent;
        while (model_q.size() != 0) begin
            run_cycle(1'b1, 0, 0);
        end
        settle_and_check(cur_name);
        report_test(cur_name, err_before);
    endtask

    initial begin
        void'($urandom(32'h2fe1));
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_word    = '0;
        out_ready  = 1'b0;
        errors     = 0;
        tests      = 0;
        passed     = 0;
        eop_in     = 0;
        eop_out    = 0;
        in_taken   = 1'b0;
        saw_valid  = 1'b0;
        load_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        cur_name = "reset_state";
        check_flag(cur_name, 1'b0, out_valid);
        check_flag(cur_name, 1'b1, in_ready);
        check_count(cur_name, eth_buf_pkg::pkt_cnt_t'(0), pkt_count);
        report_test(cur_name, 0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        run_mode_test();
        run_back_pressure_test();

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests, passed, tests - passed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog allows 40 cycles for each word the tests move
    initial begin
        int limit;
        int words;
        @(negedge rst);
        words = 6 + BP_OFFER;
        for (int i = 0; i < NUM_ROWS; i++) begin
            words += rows[i].frames * rows[i].words;
        end
        limit = words * 40 + 500;
        repeat (limit) @(posedge clk);
        $display("ERROR watchdog: run timed out after %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/eth_frame_buffer.sv
// Top level of the Ethernet frame buffer, packet FIFO followed by the transmit framer
`timescale 1ns/1ns
`default_nettype none

module eth_frame_buffer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid,
    input  wire eth_buf_pkg::eth_word_t in_word,
    output logic                   in_ready,
    output logic                   out_valid,
    output eth_buf_pkg::eth_word_t out_word,
    input  wire                    out_ready,
    output eth_buf_pkg::pkt_cnt_t  pkt_count
);

    // FIFO read port
    logic                   rd_en;
    logic                   rd_avail;
    eth_buf_pkg::eth_word_t rd_word;
    logic                   rd_word_valid;

    eth_pkt_fifo pkt_fifo_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_word       (in_word),
        .in_ready      (in_ready),
        .rd_en         (rd_en),
        .rd_avail      (rd_avail),
        .rd_word       (rd_word),
        .rd_word_valid (rd_word_valid),
        .pkt_count     (pkt_count)
    );

    eth_tx_framer tx_framer_i (
        .clk           (clk),
        .rst           (rst),
        .rd_avail      (rd_avail),
        .rd_en         (rd_en),
        .rd_word       (rd_word),
        .rd_word_valid (rd_word_valid),
        .out_valid     (out_valid),
        .out_word      (out_word),
        .out_ready     (out_ready)
    );

endmodule

`default_nettype wire

// File: hdl/eth_tx_framer.sv
// Transmit framer that pulls words from the packet FIFO on credit and presents a valid/ready stream
`timescale 1ns/1ns
`default_nettype none

`include "eth_buf_cfg.svh"

module eth_tx_framer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    rd_avail,
    output logic                   rd_en,
    input  wire eth_buf_pkg::eth_word_t rd_word,
    input  wire                    rd_word_valid,
    output logic                   out_valid,
    output eth_buf_pkg::eth_word_t out_word,
    input  wire                    out_ready
);

    localparam int QDEPTH = `ETH_TX_QUEUE_DEPTH;
    localparam int IDX_W  = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
    localparam int CNT_W  = $clog2(QDEPTH + 1);

    eth_buf_pkg::eth_word_t q_mem [QDEPTH];
    logic [IDX_W-1:0] q_wr_idx;
    logic [IDX_W-1:0] q_rd_idx;
    logic [CNT_W-1:0] q_count;

    // Free entries minus reads still in flight
    logic [CNT_W-1:0] credit;

    logic q_push;
    logic q_pop;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        if (idx == IDX_W'(QDEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    // A read reserves its queue slot when issued
    assign rd_en = rd_avail && (credit != '0);

    assign q_push = rd_word_valid;
    assign q_pop  = out_valid && out_ready;

    // Head of the queue is the output, held until taken
    assign out_valid = (q_count != '0);
    assign out_word  = q_mem[q_rd_idx];

    always_ff @(posedge clk) begin
        if (q_push) begin
            q_mem[q_wr_idx] <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr_idx <= '0;
            q_rd_idx <= '0;
            q_count  <= '0;
            credit   <= CNT_W'(QDEPTH);
        end else begin
            if (q_push) begin
                q_wr_idx <= next_idx(q_wr_idx);
            end
            if (q_pop) begin
                q_rd_idx <= next_idx(q_rd_idx);
            end

            case ({q_push, q_pop})
                2'b10: q_count <= q_count + 1'b1;
                2'b01: q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase

            // Returning words move a slot from in flight to filled, credit unchanged
            case ({rd_en, q_pop})
                2'b10: credit <= credit - 1'b1;
                2'b01: credit <= credit + 1'b1;
                default: credit <= credit;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/eth_pkt_fifo.sv
// Packet FIFO for 64-bit Ethernet words, cut-through or store-and-forward, read with fixed latency
`timescale 1ns/1ns
`default_nettype none

`include "eth_buf_cfg.svh"

module eth_pkt_fifo (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid,
    input  wire eth_buf_pkg::eth_word_t in_word,
    output logic                   in_ready,
    input  wire                    rd_en,
    output logic                   rd_avail,
    output eth_buf_pkg::eth_word_t rd_word,
    output logic                   rd_word_valid,
    output eth_buf_pkg::pkt_cnt_t  pkt_count
);

    localparam int ADDR_WIDTH = `ETH_BUF_ADDR_WIDTH;
    localparam int PKT_MODE   = `ETH_PKT_MODE;

    // Input stage
    eth_buf_pkg::eth_word_t in_q;
    logic                   in_q_valid;

    // Pointers
    eth_buf_pkg::buf_ptr_t wr_ptr;
    eth_buf_pkg::buf_ptr_t wr_ptr_next;
    eth_buf_pkg::buf_ptr_t commit_ptr;
    eth_buf_pkg::buf_ptr_t rd_ptr;
    eth_buf_pkg::buf_ptr_t rd_limit;

    // Read path
    logic                   rd_en_q;
    eth_buf_pkg::eth_word_t ram_word;

    // Frame accounting
    logic eop_written;
    logic eop_read;

    // Register the input transfer, the memory write follows on the next edge
    always_ff @(posedge clk) begin
        if (rst) begin
            in_q_valid <= 1'b0;
        end else begin
            in_q_valid <= in_valid && in_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            in_q <= in_word;
        end
    end

    // The staged word is always written, space was reserved when it was accepted
    assign wr_ptr_next = wr_ptr + eth_buf_pkg::buf_ptr_t'(in_q_valid);

    // Accept only if the word in flight still leaves a free slot
    assign in_ready = !((wr_ptr_next[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]) &&
                        (wr_ptr_next[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]));

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr_next;
            // Commit point moves past each frame's last word
            if (in_q_valid && in_q.eop) begin
                commit_ptr <= wr_ptr_next;
            end
        end
    end

    eth_word_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) word_ram_i (
        .clk     (clk),
        .wr_en   (in_q_valid),
        .wr_addr (wr_ptr[ADDR_WIDTH-1:0]),
        .wr_word (in_q),
        .rd_en   (rd_en),
        .rd_addr (rd_ptr[ADDR_WIDTH-1:0]),
        .rd_word (ram_word)
    );

    // Readable window ends at the commit point in store-and-forward mode
    assign rd_limit = (PKT_MODE != 0) ? commit_ptr : wr_ptr;
    assign rd_avail = (rd_ptr != rd_limit);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Second read stage, word valid two cycles after rd_en
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en_q       <= 1'b0;
            rd_word_valid <= 1'b0;
        end else begin
            rd_en_q       <= rd_en;
            rd_word_valid <= rd_en_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            rd_word <= ram_word;
        end
    end

    // Frames held = eop words written minus eop words handed out
    assign eop_written = in_q_valid && in_q.eop;
    assign eop_read    = rd_word_valid && rd_word.eop;

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_count <= '0;
        end else begin
            case ({eop_written, eop_read})
                2'b10: pkt_count <= pkt_count + 1'b1;
                2'b01: pkt_count <= pkt_count - 1'b1;
                default: pkt_count <= pkt_count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/eth_word_ram.sv
// Buffer word storage with one write port and one registered read port, used by the packet FIFO
`timescale 1ns/1ns
`default_nettype none

`include "eth_buf_cfg.svh"

module eth_word_ram #(
    parameter int ADDR_WIDTH = `ETH_BUF_ADDR_WIDTH
) (
    input  wire                    clk,
    input  wire                    wr_en,
    input  wire [ADDR_WIDTH-1:0]   wr_addr,
    input  wire eth_buf_pkg::eth_word_t wr_word,
    input  wire                    rd_en,
    input  wire [ADDR_WIDTH-1:0]   rd_addr,
    output eth_buf_pkg::eth_word_t rd_word
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    eth_buf_pkg::eth_word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // Read data lands one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/eth_buf_pkg.sv
// Shared word, pointer and count types for the Ethernet frame buffer modules and testbench
`default_nettype none

`include "eth_buf_cfg.svh"

package eth_buf_pkg;

    // One buffer word, 68 bits
    // byte_cnt is only meaningful on the eop word, 0 means all 8 bytes valid
    typedef struct packed {
        logic [63:0] data;
        logic        eop;
        logic [2:0]  byte_cnt;
    } eth_word_t;

    // Extra MSB is the wrap bit, separates full from empty
    typedef logic [`ETH_BUF_ADDR_WIDTH:0] buf_ptr_t;

    // Counts up to a buffer full of single-word frames
    typedef logic [`ETH_BUF_ADDR_WIDTH:0] pkt_cnt_t;

endpackage

`default_nettype wire

// File: include/eth_buf_cfg.svh
// Build-time sizing and mode settings for the Ethernet frame buffer, included by RTL and testbench
`ifndef ETH_BUF_CFG_SVH
`define ETH_BUF_CFG_SVH

// Buffer depth is 2**ETH_BUF_ADDR_WIDTH words of 64 bits
`define ETH_BUF_ADDR_WIDTH 5

// Packet mode
// 0 = cut-through, words readable as soon as written
// 1 = store-and-forward, words readable once their frame's eop word is written
`define ETH_PKT_MODE 0

// Output queue entries in the transmit framer
`define ETH_TX_QUEUE_DEPTH 4

`endif
